/* design/tl_arb_burst.sv */
// Port 0 has the highest priority. A granted port keeps its grant through a stall or a burst.
`default_nettype none

module tl_arb_burst #(
    parameter int N = 2
) (
    input  wire          clk,
    input  wire          resetn,
    input  wire  [N-1:0] valids,
    output logic [N-1:0] grants,
    input  wire          ready,
    input  wire          last
);

    logic [N-1:0] pick;
    logic [N-1:0] lock_grant;
    logic         locked;
    logic         active;

    assign pick   = valids & (~valids + N'(1)); // Keeps only the lowest set bit.
    assign grants = locked ? lock_grant : pick;
    assign active = |(valids & grants);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            locked     <= 1'b0;
            lock_grant <= '0;
        end else if (active) begin
            if (ready && last) begin
                locked <= 1'b0; // The final beat of the transfer is accepted.
            end else begin
                locked     <= 1'b1; // Stalled beat or open burst.
                lock_grant <= grants;
            end
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!resetn)
        $onehot0(grants)
    );

endmodule

`default_nettype wire

/* design/tl_if.sv */
// Carries only the TL-UL A and D channels. There are no param, user, sink or corrupt fields.
`default_nettype none

interface tl_if #(
    parameter int AW       = 32,
    parameter int DW       = 32,
    parameter int SIZE_W   = 3,
    parameter int SOURCE_W = 4
);

    tl_pkg::a_opcode_e     a_opcode;
    logic [SIZE_W-1:0]     a_size;
    logic [SOURCE_W-1:0]   a_source;
    logic [AW-1:0]         a_address;
    logic [DW-1:0]         a_data;
    logic [DW/8-1:0]       a_mask;
    logic                  a_valid;
    logic                  a_ready;

    tl_pkg::d_opcode_e     d_opcode;
    logic [SIZE_W-1:0]     d_size;
    logic [SOURCE_W-1:0]   d_source;
    logic [DW-1:0]         d_data;
    logic                  d_denied;
    logic                  d_valid;
    logic                  d_ready;

    modport master (
        output a_opcode, a_size, a_source, a_address, a_data, a_mask, a_valid, d_ready,
        input  a_ready, d_opcode, d_size, d_source, d_data, d_denied, d_valid
    );

    modport slave (
        input  a_opcode, a_size, a_source, a_address, a_data, a_mask, a_valid, d_ready,
        output a_ready, d_opcode, d_size, d_source, d_data, d_denied, d_valid
    );

endinterface

`default_nettype wire

/* design/tl_mux.sv */
// N must be at least 2. The top clog2(N) bits of source name the upstream port of a response.
`default_nettype none

module tl_mux #(
    parameter int N        = 2,
    parameter int AW       = 32,
    parameter int DW       = 32,
    parameter int SIZE_W   = 3,
    parameter int SOURCE_W = 4
) (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire  [3*N-1:0]        up_a_opcode,
    input  wire  [SIZE_W*N-1:0]   up_a_size,
    input  wire  [SOURCE_W*N-1:0] up_a_source,
    input  wire  [AW*N-1:0]       up_a_address,
    input  wire  [DW*N-1:0]       up_a_data,
    input  wire  [DW/8*N-1:0]     up_a_mask,
    input  wire  [N-1:0]          up_a_valid,
    output logic [N-1:0]          up_a_ready,
    output logic [3*N-1:0]        up_d_opcode,
    output logic [SIZE_W*N-1:0]   up_d_size,
    output logic [SOURCE_W*N-1:0] up_d_source,
    output logic [DW*N-1:0]       up_d_data,
    output logic [N-1:0]          up_d_denied,
    output logic [N-1:0]          up_d_valid,
    input  wire  [N-1:0]          up_d_ready,
    tl_if.master                  ds
);

    localparam int unsigned BYTE_LOG2 = $clog2(DW / 8);
    localparam int          IDX_W     = $clog2(N);
    localparam int          MW        = DW / 8;

    logic [N-1:0]          grants;
    logic [2:0]            sel_opcode;
    logic [SIZE_W-1:0]     sel_size;
    logic [SOURCE_W-1:0]   sel_source;
    logic [AW-1:0]         sel_address;
    logic [DW-1:0]         sel_data;
    logic [MW-1:0]         sel_mask;
    tl_pkg::beat_t         a_cnt;
    tl_pkg::beat_t         a_len;
    logic                  a_last;
    logic [IDX_W-1:0]      d_idx;
    logic [N-1:0]          d_sel;

    tl_arb_burst #(
        .N(N)
    ) u_arb (
        .clk    (clk),
        .resetn (resetn),
        .valids (up_a_valid),
        .grants (grants),
        .ready  (ds.a_ready),
        .last   (a_last)
    );

    // AND-OR select, since grants is one-hot or zero.
    always_comb begin
        sel_opcode  = '0;
        sel_size    = '0;
        sel_source  = '0;
        sel_address = '0;
        sel_data    = '0;
        sel_mask    = '0;
        for (int i = 0; i < N; i++) begin
            if (grants[i]) begin
                sel_opcode  = sel_opcode | up_a_opcode[3*i +: 3];
                sel_size    = sel_size | up_a_size[SIZE_W*i +: SIZE_W];
                sel_source  = sel_source | up_a_source[SOURCE_W*i +: SOURCE_W];
                sel_address = sel_address | up_a_address[AW*i +: AW];
                sel_data    = sel_data | up_a_data[DW*i +: DW];
                sel_mask    = sel_mask | up_a_mask[MW*i +: MW];
            end
        end
    end

    assign ds.a_opcode  = tl_pkg::a_opcode_e'(sel_opcode);
    assign ds.a_size    = sel_size;
    assign ds.a_source  = sel_source;
    assign ds.a_address = sel_address;
    assign ds.a_data    = sel_data;
    assign ds.a_mask    = sel_mask;
    assign ds.a_valid   = |(up_a_valid & grants);
    assign up_a_ready   = grants & {N{ds.a_ready}};

    assign a_len  = tl_pkg::beats_minus_one(ds.a_size, BYTE_LOG2);
    assign a_last = (ds.a_opcode == tl_pkg::get) || (a_cnt == a_len); // Get has one A beat.

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            a_cnt <= '0;
        end else if (ds.a_valid && ds.a_ready) begin
            a_cnt <= a_last ? '0 : a_cnt + tl_pkg::beat_t'(1);
        end
    end

    assign d_idx       = ds.d_source[SOURCE_W-1 -: IDX_W];
    assign d_sel       = N'(1) << d_idx;
    assign up_d_valid  = d_sel & {N{ds.d_valid}};
    assign ds.d_ready  = |(d_sel & up_d_ready);
    assign up_d_opcode = {N{ds.d_opcode}};
    assign up_d_size   = {N{ds.d_size}};
    assign up_d_source = {N{ds.d_source}};
    assign up_d_data   = {N{ds.d_data}};
    assign up_d_denied = {N{ds.d_denied}};

    // Needs both stable upstream masters and an arbiter that holds a stalled grant.
    a_payload_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        ds.a_valid && !ds.a_ready |=> ds.a_valid && $stable({ds.a_opcode, ds.a_size,
            ds.a_source, ds.a_address, ds.a_data, ds.a_mask})
    );

endmodule

`default_nettype wire

/* design/tl_pkg.sv */
// Defines only the TL-UL Get and Put opcodes. A burst may have at most 256 beats.
`default_nettype none

package tl_pkg;

    localparam int BEAT_W = 8;

    typedef logic [BEAT_W-1:0] beat_t;

    typedef enum logic [2:0] {
        put_full_data    = 3'd0,
        put_partial_data = 3'd1,
        get              = 3'd4
    } a_opcode_e;

    typedef enum logic [2:0] {
        access_ack      = 3'd0,
        access_ack_data = 3'd1
    } d_opcode_e;

    typedef enum logic [1:0] {
        idle        = 2'd0,
        write_burst = 2'd1,
        respond     = 2'd2
    } ram_state_e;

    // A transfer of 2**size bytes on a bus of 2**byte_log2 bytes per beat.
    function automatic beat_t beats_minus_one(
        input int unsigned size,
        input int unsigned byte_log2
    );
        beat_t beats;
        beats = '0;
        if (size > byte_log2) begin
            beats = beat_t'((1 << (size - byte_log2)) - 1);
        end
        return beats;
    endfunction

endpackage

`default_nettype wire

/* design/tl_ram.sv */
// Serves one transaction at a time. DEPTH must be at least 2 and the contents are not reset.
`default_nettype none

module tl_ram #(
    parameter int AW       = 32,
    parameter int DW       = 32,
    parameter int SIZE_W   = 3,
    parameter int SOURCE_W = 4,
    parameter int DEPTH    = 64
) (
    input wire  clk,
    input wire  resetn,
    tl_if.slave bus
);

    localparam int unsigned BYTE_LOG2 = $clog2(DW / 8);
    localparam int          MW        = DW / 8;
    localparam int          IW        = $clog2(DEPTH);
    localparam int          WAW       = AW - BYTE_LOG2;
    localparam int unsigned RAM_BYTES = DEPTH * MW;

    logic [DW-1:0]         mem [DEPTH];
    tl_pkg::ram_state_e    state;
    logic [WAW-1:0]        waddr_q;
    tl_pkg::beat_t         cnt_q;
    tl_pkg::beat_t         len_q;
    logic [SOURCE_W-1:0]   src_q;
    logic [SIZE_W-1:0]     size_q;
    logic                  is_get_q;
    logic                  denied_q;
    logic [WAW-1:0]        a_wa;
    logic [WAW-1:0]        cur_wa;
    logic                  cur_oob;
    logic                  rd_oob;
    logic                  a_xfer;
    logic                  d_xfer;
    logic                  a_get;
    tl_pkg::beat_t         a_len;

    assign a_wa    = bus.a_address[AW-1:BYTE_LOG2];
    assign cur_wa  = (state == tl_pkg::idle) ? a_wa : waddr_q; // Word of this A beat.
    assign cur_oob = cur_wa >= WAW'(DEPTH);
    assign rd_oob  = waddr_q >= WAW'(DEPTH);
    assign a_xfer  = bus.a_valid && bus.a_ready;
    assign d_xfer  = bus.d_valid && bus.d_ready;
    assign a_get   = bus.a_opcode == tl_pkg::get;
    assign a_len   = tl_pkg::beats_minus_one(bus.a_size, BYTE_LOG2);

    assign bus.a_ready  = state != tl_pkg::respond;
    assign bus.d_valid  = state == tl_pkg::respond;
    assign bus.d_opcode = is_get_q ? tl_pkg::access_ack_data : tl_pkg::access_ack;
    assign bus.d_size   = size_q;
    assign bus.d_source = src_q;
    assign bus.d_denied = is_get_q ? rd_oob : denied_q;
    assign bus.d_data   = (is_get_q && !rd_oob) ? mem[waddr_q[IW-1:0]] : '0;

    always_ff @(posedge clk) begin
        if (a_xfer && !a_get && !cur_oob) begin
            for (int b = 0; b < MW; b++) begin
                if (bus.a_mask[b]) begin
                    mem[cur_wa[IW-1:0]][8*b +: 8] <= bus.a_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= tl_pkg::idle;
            waddr_q  <= '0;
            cnt_q    <= '0;
            len_q    <= '0;
            src_q    <= '0;
            size_q   <= '0;
            is_get_q <= 1'b0;
            denied_q <= 1'b0;
        end else begin
            case (state)
                tl_pkg::idle: begin
                    if (a_xfer) begin
                        src_q    <= bus.a_source;
                        size_q   <= bus.a_size;
                        len_q    <= a_len;
                        is_get_q <= a_get;
                        denied_q <= cur_oob;
                        cnt_q    <= '0;
                        if (a_get) begin
                            waddr_q <= a_wa; // First word of the read burst.
                            state   <= tl_pkg::respond;
                        end else if (a_len == '0) begin
                            state <= tl_pkg::respond;
                        end else begin
                            waddr_q <= a_wa + WAW'(1);
                            cnt_q   <= tl_pkg::beat_t'(1);
                            state   <= tl_pkg::write_burst;
                        end
                    end
                end
                tl_pkg::write_burst: begin
                    if (a_xfer) begin
                        denied_q <= denied_q | cur_oob; // One bad beat denies the whole Put.
                        waddr_q  <= waddr_q + WAW'(1);
                        cnt_q    <= cnt_q + tl_pkg::beat_t'(1);
                        if (cnt_q == len_q) begin
                            state <= tl_pkg::respond;
                        end
                    end
                end
                tl_pkg::respond: begin
                    if (d_xfer) begin
                        if (!is_get_q || cnt_q == len_q) begin
                            state <= tl_pkg::idle;
                        end else begin
                            cnt_q   <= cnt_q + tl_pkg::beat_t'(1);
                            waddr_q <= waddr_q + WAW'(1);
                        end
                    end
                end
                default: begin
                    state <= tl_pkg::idle;
                end
            endcase
        end
    end

    a_size_fits: assert property (
        @(posedge clk) disable iff (!resetn)
        bus.a_valid |-> (32'd1 << bus.a_size) <= RAM_BYTES
    );

endmodule

`default_nettype wire

/* design/tl_subsys.sv */
// Shares one RAM among N masters. N must be at least 2 and the top source bits name the master.
`default_nettype none

module tl_subsys #(
    parameter int N        = 2,
    parameter int AW       = 32,
    parameter int DW       = 32,
    parameter int SIZE_W   = 3,
    parameter int SOURCE_W = 4,
    parameter int DEPTH    = 64
) (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire  [3*N-1:0]        up_a_opcode,
    input  wire  [SIZE_W*N-1:0]   up_a_size,
    input  wire  [SOURCE_W*N-1:0] up_a_source,
    input  wire  [AW*N-1:0]       up_a_address,
    input  wire  [DW*N-1:0]       up_a_data,
    input  wire  [DW/8*N-1:0]     up_a_mask,
    input  wire  [N-1:0]          up_a_valid,
    output wire  [N-1:0]          up_a_ready,
    output wire  [3*N-1:0]        up_d_opcode,
    output wire  [SIZE_W*N-1:0]   up_d_size,
    output wire  [SOURCE_W*N-1:0] up_d_source,
    output wire  [DW*N-1:0]       up_d_data,
    output wire  [N-1:0]          up_d_denied,
    output wire  [N-1:0]          up_d_valid,
    input  wire  [N-1:0]          up_d_ready
);

    tl_if #(
        .AW       (AW),
        .DW       (DW),
        .SIZE_W   (SIZE_W),
        .SOURCE_W (SOURCE_W)
    ) ram_bus ();

    tl_mux #(
        .N        (N),
        .AW       (AW),
        .DW       (DW),
        .SIZE_W   (SIZE_W),
        .SOURCE_W (SOURCE_W)
    ) u_mux (
        .clk          (clk),
        .resetn       (resetn),
        .up_a_opcode  (up_a_opcode),
        .up_a_size    (up_a_size),
        .up_a_source  (up_a_source),
        .up_a_address (up_a_address),
        .up_a_data    (up_a_data),
        .up_a_mask    (up_a_mask),
        .up_a_valid   (up_a_valid),
        .up_a_ready   (up_a_ready),
        .up_d_opcode  (up_d_opcode),
        .up_d_size    (up_d_size),
        .up_d_source  (up_d_source),
        .up_d_data    (up_d_data),
        .up_d_denied  (up_d_denied),
        .up_d_valid   (up_d_valid),
        .up_d_ready   (up_d_ready),
        .ds           (ram_bus.master)
    );

    tl_ram #(
        .AW       (AW),
        .DW       (DW),
        .SIZE_W   (SIZE_W),
        .SOURCE_W (SOURCE_W),
        .DEPTH    (DEPTH)
    ) u_ram (
        .clk    (clk),
        .resetn (resetn),
        .bus    (ram_bus.slave)
    );

endmodule

`default_nettype wire

/* sim/tb_tl_subsys.sv */
// Assumes two masters, 32-bit data and a 64-word RAM, and each port keeps one transaction open.
`default_nettype none

module tb_tl_subsys;

    localparam int N        = 2;
    localparam int AW       = 32;
    localparam int DW       = 32;
    localparam int SIZE_W   = 3;
    localparam int SOURCE_W = 4;
    localparam int DEPTH    = 64;
    localparam int TIMEOUT  = 100;

    logic                   clk;
    logic                   resetn;
    logic [3*N-1:0]         up_a_opcode;
    logic [SIZE_W*N-1:0]    up_a_size;
    logic [SOURCE_W*N-1:0]  up_a_source;
    logic [AW*N-1:0]        up_a_address;
    logic [DW*N-1:0]        up_a_data;
    logic [DW/8*N-1:0]      up_a_mask;
    logic [N-1:0]           up_a_valid;
    logic [N-1:0]           up_a_ready;
    logic [3*N-1:0]         up_d_opcode;
    logic [SIZE_W*N-1:0]    up_d_size;
    logic [SOURCE_W*N-1:0]  up_d_source;
    logic [DW*N-1:0]        up_d_data;
    logic [N-1:0]           up_d_denied;
    logic [N-1:0]           up_d_valid;
    logic [N-1:0]           up_d_ready;

    logic [31:0] sb [DEPTH];  // Model of the RAM contents.
    logic [2:0]  exp_op [N];
    logic [2:0]  exp_size [N];
    logic [3:0]  exp_src [N];
    logic        exp_den [N];
    int          exp_word [N];
    logic [31:0] exp_data [N];
    int          d_left [N];
    int          a_cnt [N];
    logic [N-1:0] pending;
    logic [N-1:0] a_open;
    logic [31:0] lfsr;
    string       test_name;
    int          errors;
    int          err_start;
    int          tests_run;
    int          tests_bad;

    tl_subsys #(
        .N        (N),
        .AW       (AW),
        .DW       (DW),
        .SIZE_W   (SIZE_W),
        .SOURCE_W (SOURCE_W),
        .DEPTH    (DEPTH)
    ) DUT (
        .clk          (clk),
        .resetn       (resetn),
        .up_a_opcode  (up_a_opcode),
        .up_a_size    (up_a_size),
        .up_a_source  (up_a_source),
        .up_a_address (up_a_address),
        .up_a_data    (up_a_data),
        .up_a_mask    (up_a_mask),
        .up_a_valid   (up_a_valid),
        .up_a_ready   (up_a_ready),
        .up_d_opcode  (up_d_opcode),
        .up_d_size    (up_d_size),
        .up_d_source  (up_d_source),
        .up_d_data    (up_d_data),
        .up_d_denied  (up_d_denied),
        .up_d_valid   (up_d_valid),
        .up_d_ready   (up_d_ready)
    );

    always #20 clk = ~clk;

    // Taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] draw(input int bits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < bits; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Beats of an A request on a 4-byte bus.
    function automatic int beat_count(input logic [2:0] op, input logic [2:0] size);
        if (op == tl_pkg::get || size <= 3'd2) begin
            return 1;
        end
        return 1 << (size - 3'd2);
    endfunction

    always_comb begin
        for (int p = 0; p < N; p++) begin
            if (exp_den[p] || exp_word[p] >= DEPTH) begin
                exp_data[p] = '0;
            end else begin
                exp_data[p] = sb[exp_word[p]];
            end
        end
    end

    // Follows the handshakes on both channels of every port.
    always @(posedge clk) begin
        for (int p = 0; p < N; p++) begin
            if (up_d_valid[p] && up_d_ready[p]) begin
                exp_word[p] <= exp_word[p] + 1;
                d_left[p]   <= d_left[p] - 1;
                if (d_left[p] == 1) begin
                    pending[p] <= 1'b0;
                end
            end
            if (up_a_valid[p] && up_a_ready[p]) begin
                if (a_cnt[p] + 1 >= beat_count(up_a_opcode[3*p +: 3], up_a_size[3*p +: 3])) begin
                    a_open[p] <= 1'b0;
                    a_cnt[p]  <= 0;
                end else begin
                    a_open[p] <= 1'b1;
                    a_cnt[p]  <= a_cnt[p] + 1;
                end
            end
        end
    end

    a_ready_onehot: assert property (@(posedge clk) disable iff (!resetn) $onehot0(up_a_ready))
        else begin
            errors++;
            $display("Error %s: up_a_ready expected one-hot, actual %b", test_name,
                $sampled(up_a_ready));
        end

    for (genvar p = 0; p < N; p++) begin : g_port
        a_burst_held: assert property (@(posedge clk) disable iff (!resetn)
            a_open[p] |-> !up_a_ready[1-p])
            else begin
                errors++;
                $display("Error %s: port %0d was accepted inside a burst of port %0d",
                    test_name, 1 - p, p);
            end

        a_resp_fields: assert property (@(posedge clk) disable iff (!resetn)
            up_d_valid[p] && up_d_ready[p] |->
            {up_d_opcode[3*p +: 3], up_d_size[3*p +: 3], up_d_source[4*p +: 4], up_d_denied[p]}
            == {exp_op[p], exp_size[p], exp_src[p], exp_den[p]})
            else begin
                errors++;
                $display("Error %s: port %0d opcode/size/source/denied expected %h actual %h",
                    test_name, p, $sampled({exp_op[p], exp_size[p], exp_src[p], exp_den[p]}),
                    $sampled({up_d_opcode[3*p +: 3], up_d_size[3*p +: 3],
                    up_d_source[4*p +: 4], up_d_denied[p]}));
            end

        a_resp_data: assert property (@(posedge clk) disable iff (!resetn)
            up_d_valid[p] && up_d_ready[p] && exp_op[p] == tl_pkg::access_ack_data |->
            up_d_data[32*p +: 32] == exp_data[p])
            else begin
                errors++;
                $display("Error %s: port %0d data expected %h actual %h", test_name, p,
                    $sampled(exp_data[p]), $sampled(up_d_data[32*p +: 32]));
            end

        a_resp_routed: assert property (@(posedge clk) disable iff (!resetn)
            up_d_valid[p] |-> pending[p] && up_d_source[4*p+3] == p)
            else begin
                errors++;
                $display("Error %s: port %0d response expected source index %0d actual %h",
                    test_name, p, p, $sampled(up_d_source[4*p +: 4]));
            end

        a_resp_stalled: assert property (@(posedge clk) disable iff (!resetn)
            up_d_valid[p] && !up_d_ready[p] |=> up_d_valid[p] &&
            $stable({up_d_opcode[3*p +: 3], up_d_size[3*p +: 3], up_d_source[4*p +: 4],
            up_d_data[32*p +: 32], up_d_denied[p]}))
            else begin
                errors++;
                $display("Error %s: port %0d response moved while d_ready was low", test_name, p);
            end
    end

    task automatic expect_d(input int p, input logic [2:0] op, input logic [2:0] size,
                            input logic [3:0] src, input int word, input int beats,
                            input logic den);
        exp_op[p]   <= op;
        exp_size[p] <= size;
        exp_src[p]  <= src;
        exp_den[p]  <= den;
        exp_word[p] <= word;
        d_left[p]   <= beats;
        pending[p]  <= 1'b1;
    endtask

    task automatic send_a(input int p, input logic [2:0] op, input logic [2:0] size,
                          input logic [3:0] src, input int word, input logic [31:0] data,
                          input logic [3:0] mask);
        int waited;
        bit done;
        up_a_opcode[3*p +: 3]    <= op;
        up_a_size[3*p +: 3]      <= size;
        up_a_source[4*p +: 4]    <= src;
        up_a_address[32*p +: 32] <= 32'(word) << 2;
        up_a_data[32*p +: 32]    <= data;
        up_a_mask[4*p +: 4]      <= mask;
        up_a_valid[p]            <= 1'b1;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
            done = up_a_valid[p] && up_a_ready[p];
        end
        if (!done) begin
            errors++;
            $display("Timeout in %s: port %0d A beat was never accepted", test_name, p);
        end
    endtask

    task automatic wait_resp(input int p, input bit stall);
        int waited;
        waited = 0;
        while (pending[p] && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
            if (stall) begin
                up_d_ready[p] <= (waited % 4 == 0); // Three idle cycles per ready cycle.
            end
        end
        if (pending[p]) begin
            errors++;
            $display("Timeout in %s: port %0d response did not complete", test_name, p);
        end
        up_d_ready[p] <= 1'b1;
    endtask

    task automatic put_burst(input int p, input logic [2:0] op, input logic [2:0] size,
                             input logic [3:0] src, input int word, input int beats,
                             input logic [3:0] mask);
        logic [31:0] data;
        expect_d(p, tl_pkg::access_ack, size, src, 0, 1, word + beats > DEPTH);
        for (int i = 0; i < beats; i++) begin
            data = draw(32);
            if (i > 0) begin
                up_a_valid[p] <= 1'b0; // Gap between beats, only the burst lock holds the grant.
                @(posedge clk);
            end
            send_a(p, op, size, src, word, data, mask);
            for (int b = 0; b < 4; b++) begin
                if (word + i < DEPTH && mask[b]) begin
                    sb[word + i][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        up_a_valid[p] <= 1'b0;
        wait_resp(p, 1'b0);
    endtask

    task automatic get_burst(input int p, input logic [2:0] size, input logic [3:0] src,
                             input int word, input int beats, input bit stall);
        expect_d(p, tl_pkg::access_ack_data, size, src, word, beats, word >= DEPTH);
        send_a(p, tl_pkg::get, size, src, word, '0, 4'hf);
        up_a_valid[p] <= 1'b0;
        wait_resp(p, stall);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        @(posedge clk);
        tests_run++;
        if (errors != err_start) begin
            tests_bad++;
            $display("Test %s: FAIL with %0d errors", test_name, errors - err_start);
        end else begin
            $display("Test %s: ok", test_name);
        end
    endtask

    initial begin
        logic [3:0] pmask;
        clk          = 1'b0;
        resetn       = 1'b0;
        lfsr         = 32'hfd827dba;
        up_a_opcode  = '0;
        up_a_size    = '0;
        up_a_source  = '0;
        up_a_address = '0;
        up_a_data    = '0;
        up_a_mask    = '0;
        up_a_valid   = '0;
        up_d_ready   = '1;
        pending      = '0;
        a_open       = '0;
        errors       = 0;
        tests_run    = 0;
        tests_bad    = 0;
        test_name    = "reset";
        for (int p = 0; p < N; p++) begin
            exp_op[p]   = '0;
            exp_size[p] = '0;
            exp_src[p]  = '0;
            exp_den[p]  = 1'b0;
            exp_word[p] = 0;
            d_left[p]   = 0;
            a_cnt[p]    = 0;
        end
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);

        start_test("read_after_write");
        put_burst(0, tl_pkg::put_full_data, 3'd2, 4'h3, 0, 1, 4'hf);
        get_burst(0, 3'd2, 4'h5, 0, 1, 1'b0);
        end_test();

        start_test("burst_atomicity");
        fork
            put_burst(0, tl_pkg::put_full_data, 3'd4, 4'h1, 16, 4, 4'hf);
            put_burst(1, tl_pkg::put_full_data, 3'd4, 4'h9, 32, 4, 4'hf);
        join
        get_burst(0, 3'd4, 4'h2, 16, 4, 1'b0);
        get_burst(1, 3'd4, 4'ha, 32, 4, 1'b0);
        end_test();

        start_test("response_routing");
        fork
            get_burst(0, 3'd2, 4'h7, 33, 1, 1'b0);
            get_burst(1, 3'd2, 4'hf, 17, 1, 1'b0);
        join
        end_test();

        start_test("partial_write");
        pmask = 4'(draw(4));
        put_burst(1, tl_pkg::put_full_data, 3'd2, 4'hc, 5, 1, 4'hf);
        put_burst(1, tl_pkg::put_partial_data, 3'd2, 4'hd, 5, 1, pmask);
        get_burst(1, 3'd2, 4'he, 5, 1, 1'b0);
        end_test();

        start_test("denied");
        put_burst(0, tl_pkg::put_full_data, 3'd2, 4'h4, DEPTH, 1, 4'hf);
        get_burst(0, 3'd2, 4'h6, DEPTH + 6, 1, 1'b0);
        get_burst(0, 3'd2, 4'h0, 0, 1, 1'b0); // Word 0 shares low index bits with DEPTH.
        end_test();

        start_test("back_pressure");
        get_burst(1, 3'd4, 4'hb, 16, 4, 1'b1);
        get_burst(0, 3'd4, 4'h2, 32, 4, 1'b1);
        end_test();

        repeat (2) @(posedge clk);
        $display("Summary: %0d tests, %0d failing, %0d errors", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
design/tl_pkg.sv
design/tl_if.sv
design/tl_arb_burst.sv
design/tl_mux.sv
design/tl_ram.sv
design/tl_subsys.sv
sim/tb_tl_subsys.sv
